/* src/rename_pkg.sv */
// rename package
// sizes, index types, port structs and ROB entry states shared by the
// register rename and retirement blocks

package rename_pkg;

	//----------------------------------------------------------------------
	// sizes
	//----------------------------------------------------------------------
	localparam int ARCH_REG_NUM  = 32;
	localparam int PREG_NUM      = 64;
	localparam int ROB_DEPTH_MAX = PREG_NUM - ARCH_REG_NUM; // free list can never run dry

	localparam int AREG_W    = $clog2(ARCH_REG_NUM);
	localparam int PREG_W    = $clog2(PREG_NUM);
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH_MAX);

	typedef logic [AREG_W-1:0]    areg_idx_t;
	typedef logic [PREG_W-1:0]    preg_idx_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;   // smaller robs use the low bits

	// state of one rob slot
	typedef enum logic [1:0] {
		ROB_EMPTY,
		ROB_BUSY,  // dispatched, waiting on completion
		ROB_DONE   // completed, may retire once at head
	} rob_state_e;

	//----------------------------------------------------------------------
	// port structs
	//----------------------------------------------------------------------
	typedef struct packed {
		logic      valid;
		areg_idx_t dest_areg;
		areg_idx_t opa_areg;
		areg_idx_t opb_areg;
	} disp_req_t;

	typedef struct packed {
		logic      valid;     // request accepted this cycle
		preg_idx_t dest_preg; // Tnew
		preg_idx_t old_preg;  // Told
		preg_idx_t opa_preg;
		logic      opa_rdy;
		preg_idx_t opb_preg;
		logic      opb_rdy;
		rob_idx_t  rob_idx;
	} rename_rsp_t;

	typedef struct packed {
		logic      valid;
		preg_idx_t preg;
	} cdb_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
	} complete_t;

	typedef struct packed {
		logic      valid;
		areg_idx_t areg;
		preg_idx_t new_preg;
		preg_idx_t old_preg;  // goes back to the free list
	} retire_t;

endpackage : rename_pkg

/* src/map_table.sv */
// map table
// architectural to physical register map with one ready bit per physical
// register, combinational lookups with cdb bypass on the ready bits

module map_table (
	input                         clk,
	input                         rst_n_i,

	input  logic                  dispatch_fire_i,  // rename accepted this cycle
	input  rename_pkg::disp_req_t disp_req_i,
	input  rename_pkg::preg_idx_t new_preg_i,       // Tnew from free list
	input  rename_pkg::cdb_t      cdb_i,

	output rename_pkg::preg_idx_t opa_preg_o,
	output logic                  opa_rdy_o,
	output rename_pkg::preg_idx_t opb_preg_o,
	output logic                  opb_rdy_o,
	output rename_pkg::preg_idx_t old_preg_o        // Told to rob
);

	import rename_pkg::*;

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	preg_idx_t map_q [ARCH_REG_NUM];  // current speculative mapping
	logic      rdy_q [PREG_NUM];      // value present in preg

	//----------------------------------------------------------------------
	// lookups
	//----------------------------------------------------------------------
	// all reads see the map before this cycle's write, so a source that
	// equals its own dest still gets the old mapping
	assign opa_preg_o = map_q[disp_req_i.opa_areg];
	assign opb_preg_o = map_q[disp_req_i.opb_areg];
	assign old_preg_o = map_q[disp_req_i.dest_areg];

	// stored ready bit or a broadcast of the same tag this cycle
	assign opa_rdy_o = rdy_q[opa_preg_o] | (cdb_i.valid && (cdb_i.preg == opa_preg_o));
	assign opb_rdy_o = rdy_q[opb_preg_o] | (cdb_i.valid && (cdb_i.preg == opb_preg_o));

	//----------------------------------------------------------------------
	// map update
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ARCH_REG_NUM; i++) begin
				map_q[i] <= preg_idx_t'(i);  // identity
			end
		end else if (dispatch_fire_i) begin
			map_q[disp_req_i.dest_areg] <= new_preg_i;
		end
	end

	//----------------------------------------------------------------------
	// ready bits
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < PREG_NUM; i++) begin
				rdy_q[i] <= 1'b1;
			end
		end else begin
			// wakeup
			if (cdb_i.valid) begin
				rdy_q[cdb_i.preg] <= 1'b1;
			end
			// new dest not yet written, placed last so the clear wins
			if (dispatch_fire_i) begin
				rdy_q[new_preg_i] <= 1'b0;
			end
		end
	end

endmodule : map_table

/* src/free_list.sv */
// free list
// circular FIFO of free physical register tags, popped on rename and
// pushed with the old tag of each retiring instruction

module free_list (
	input                         clk,
	input                         rst_n_i,

	input  logic                  pop_i,       // dispatch fire
	input  rename_pkg::retire_t   push_i,      // retirement from rob
	output rename_pkg::preg_idx_t head_preg_o  // next free tag
);

	import rename_pkg::*;

	localparam int PTR_W = $clog2(ROB_DEPTH_MAX);

	//----------------------------------------------------------------------
	// storage and pointers
	//----------------------------------------------------------------------
	preg_idx_t        fifo_q [ROB_DEPTH_MAX];
	logic [PTR_W-1:0] head_q;   // oldest free tag
	logic [PTR_W-1:0] tail_q;   // next write slot
	logic [PTR_W:0]   count_q;  // tags held, one extra bit for the full case

	logic push;

	assign push        = push_i.valid;
	assign head_preg_o = fifo_q[head_q];

	//----------------------------------------------------------------------
	// tag array
	//----------------------------------------------------------------------
	// reset loads tags ARCH_REG_NUM.. in order, so the array takes reset too
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ROB_DEPTH_MAX; i++) begin
				fifo_q[i] <= preg_idx_t'(ARCH_REG_NUM + i);
			end
		end else if (push) begin
			fifo_q[tail_q] <= push_i.old_preg;  // Told back in
		end
	end

	//----------------------------------------------------------------------
	// pointers and count
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head_q  <= '0;
			tail_q  <= '0;  // wrapped, list starts full
			count_q <= (PTR_W+1)'(ROB_DEPTH_MAX);
		end else begin
			if (pop_i) begin
				head_q <= head_q + 1'b1;
			end
			if (push) begin
				tail_q <= tail_q + 1'b1;
			end
			// pop and push together leave the count alone
			case ({pop_i, push})
				2'b10:   count_q <= count_q - 1'b1;
				2'b01:   count_q <= count_q + 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule : free_list

/* src/rob.sv */
// reorder buffer
// allocates at the tail on dispatch, marks entries done on completion and
// retires the head in order, one per cycle, handing back Told

module rob #(
	parameter int ROB_DEPTH = 16  // power of two, 4 .. ROB_DEPTH_MAX
) (
	input                         clk,
	input                         rst_n_i,

	input  logic                  dispatch_fire_i,
	input  rename_pkg::areg_idx_t dest_areg_i,
	input  rename_pkg::preg_idx_t new_preg_i,   // Tnew
	input  rename_pkg::preg_idx_t old_preg_i,   // Told
	input  rename_pkg::complete_t complete_i,

	output rename_pkg::rob_idx_t  tail_idx_o,   // slot of the next dispatch
	output logic                  full_o,
	output rename_pkg::retire_t   retire_o
);

	import rename_pkg::*;

	localparam int PTR_W = $clog2(ROB_DEPTH);

	// depth must keep the free list from running dry
	if (ROB_DEPTH < 4 || ROB_DEPTH > ROB_DEPTH_MAX ||
		(ROB_DEPTH & (ROB_DEPTH - 1)) != 0) begin : g_bad_depth
		$error("rob: ROB_DEPTH %0d out of range", ROB_DEPTH);
	end

	// payload of one slot
	typedef struct packed {
		areg_idx_t areg;
		preg_idx_t new_preg;
		preg_idx_t old_preg;
	} rob_payload_t;

	//----------------------------------------------------------------------
	// storage and pointers
	//----------------------------------------------------------------------
	rob_state_e       state_q   [ROB_DEPTH];
	rob_payload_t     payload_q [ROB_DEPTH];
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W:0]   count_q;   // occupancy

	logic             retire;    // head done, leaves this cycle
	logic [PTR_W-1:0] cmp_idx;   // completed slot, low bits only

	assign cmp_idx = complete_i.rob_idx[PTR_W-1:0];
	assign retire  = (state_q[head_q] == ROB_DONE);

	//----------------------------------------------------------------------
	// outputs
	//----------------------------------------------------------------------
	assign full_o     = (count_q == (PTR_W+1)'(ROB_DEPTH));
	assign tail_idx_o = rob_idx_t'(tail_q);  // zero extended

	always_comb begin
		retire_o.valid    = retire;
		retire_o.areg     = payload_q[head_q].areg;
		retire_o.new_preg = payload_q[head_q].new_preg;
		retire_o.old_preg = payload_q[head_q].old_preg;
	end

	//----------------------------------------------------------------------
	// entry states
	//----------------------------------------------------------------------
	// completion only hits a busy slot, dispatch only an empty tail, and
	// retire only the done head, so the three writes never collide
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				state_q[i] <= ROB_EMPTY;
			end
		end else begin
			if (complete_i.valid) begin
				state_q[cmp_idx] <= ROB_DONE;
			end
			if (retire) begin
				state_q[head_q] <= ROB_EMPTY;  // free slot
			end
			if (dispatch_fire_i) begin
				state_q[tail_q] <= ROB_BUSY;
			end
		end
	end

	// payload, written on allocation
	always_ff @(posedge clk) begin
		if (dispatch_fire_i) begin
			payload_q[tail_q] <= '{areg: dest_areg_i, new_preg: new_preg_i,
			                       old_preg: old_preg_i};
		end
	end

	//----------------------------------------------------------------------
	// head, tail and count
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (retire) begin
				head_q <= head_q + 1'b1;  // wraps, depth is a power of two
			end
			if (dispatch_fire_i) begin
				tail_q <= tail_q + 1'b1;
			end
			case ({dispatch_fire_i, retire})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // both or neither
			endcase
		end
	end

endmodule : rob

/* src/rename_core.sv */
// rename core
// joins map table, free list and reorder buffer, forms the dispatch
// accept and stall, and builds the rename response

module rename_core #(
	parameter int ROB_DEPTH = 16
) (
	input                           clk,
	input                           rst_n_i,

	input  rename_pkg::disp_req_t   disp_req_i,
	input  rename_pkg::cdb_t        cdb_i,
	input  rename_pkg::complete_t   complete_i,

	output rename_pkg::rename_rsp_t rename_rsp_o,
	output rename_pkg::retire_t     retire_o,
	output logic                    stall_o
);

	import rename_pkg::*;

	//----------------------------------------------------------------------
	// internal signals
	//----------------------------------------------------------------------
	logic      dispatch_fire;  // request accepted, state moves at this edge
	preg_idx_t fl_head_preg;   // Tnew
	preg_idx_t mt_old_preg;    // Told
	preg_idx_t mt_opa_preg;
	preg_idx_t mt_opb_preg;
	logic      mt_opa_rdy;
	logic      mt_opb_rdy;
	rob_idx_t  rob_tail_idx;
	logic      rob_full;
	retire_t   rob_retire;

	//----------------------------------------------------------------------
	// dispatch control
	//----------------------------------------------------------------------
	// only a full rob stalls, free list depth covers every rob slot
	assign stall_o       = rob_full;
	assign dispatch_fire = disp_req_i.valid & ~rob_full;

	always_comb begin
		rename_rsp_o.valid     = dispatch_fire;
		rename_rsp_o.dest_preg = fl_head_preg;
		rename_rsp_o.old_preg  = mt_old_preg;
		rename_rsp_o.opa_preg  = mt_opa_preg;
		rename_rsp_o.opa_rdy   = mt_opa_rdy;
		rename_rsp_o.opb_preg  = mt_opb_preg;
		rename_rsp_o.opb_rdy   = mt_opb_rdy;
		rename_rsp_o.rob_idx   = rob_tail_idx;
	end

	assign retire_o = rob_retire;  // also feeds the free list push

	//----------------------------------------------------------------------
	// blocks
	//----------------------------------------------------------------------
	map_table map_table_i (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.dispatch_fire_i (dispatch_fire),
		.disp_req_i      (disp_req_i),
		.new_preg_i      (fl_head_preg),
		.cdb_i           (cdb_i),
		.opa_preg_o      (mt_opa_preg),
		.opa_rdy_o       (mt_opa_rdy),
		.opb_preg_o      (mt_opb_preg),
		.opb_rdy_o       (mt_opb_rdy),
		.old_preg_o      (mt_old_preg)
	);

	free_list free_list_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.pop_i       (dispatch_fire),
		.push_i      (rob_retire),    // Told of the retiring head
		.head_preg_o (fl_head_preg)
	);

	rob #(
		.ROB_DEPTH (ROB_DEPTH)
	) rob_i (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.dispatch_fire_i (dispatch_fire),
		.dest_areg_i     (disp_req_i.dest_areg),
		.new_preg_i      (fl_head_preg),
		.old_preg_i      (mt_old_preg),
		.complete_i      (complete_i),
		.tail_idx_o      (rob_tail_idx),
		.full_o          (rob_full),
		.retire_o        (rob_retire)
	);

endmodule : rename_core

/* verif/tb_clk_gen.sv */
// testbench clock and reset
// 20 ns clock, reset held low for the first 8 rising edges

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 10;
	localparam int RST_CYCLES  = 8;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;  // released on an edge, like the stimulus
	end

endmodule : tb_clk_gen

/* verif/rename_core_chk.sv */
// rename core checker
// free list occupancy limits, rob occupancy bound and completion targets,
// bound into the core and wired to its free list and rob

module rename_core_chk #(
	parameter int ROB_DEPTH = 16
) (
	input logic                                       clk_i,
	input logic                                       rst_n_i,
	input logic                                       fl_pop_i,
	input logic                                       fl_push_i,
	input logic [$clog2(rename_pkg::ROB_DEPTH_MAX):0] fl_count_i,
	input logic [$clog2(ROB_DEPTH):0]                 rob_count_i,
	input logic                                       cmp_valid_i,
	input rename_pkg::rob_state_e                     cmp_state_i  // state of the named slot
);
	timeunit 1ns;
	timeprecision 1ps;

	import rename_pkg::*;

	// free list bounds
	a_fl_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(fl_push_i && (fl_count_i == ROB_DEPTH_MAX)))
		else $error("free list pushed while full");

	a_fl_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(fl_pop_i && (fl_count_i == 0)))
		else $error("free list popped while empty");

	// rob bounds
	a_rob_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rob_count_i <= ROB_DEPTH)
		else $error("rob occupancy above its depth");

	a_cmp_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cmp_valid_i |-> (cmp_state_i == ROB_BUSY))
		else $error("completion names a slot that is not busy");

endmodule : rename_core_chk

bind rename_core rename_core_chk #(.ROB_DEPTH(ROB_DEPTH)) chk_i (
	.clk_i       (clk),
	.rst_n_i     (rst_n_i),
	.fl_pop_i    (free_list_i.pop_i),
	.fl_push_i   (free_list_i.push),
	.fl_count_i  (free_list_i.count_q),
	.rob_count_i (rob_i.count_q),
	.cmp_valid_i (complete_i.valid),
	.cmp_state_i (rob_i.state_q[rob_i.cmp_idx])
);

/* verif/rename_core_tb.sv */
// rename core testbench
// directed tests against a reference model of map, ready bits, free FIFO
// and rob, checked every cycle on the falling edge

module rename_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rename_pkg::*;

	localparam int ROB_DEPTH      = 16;
	localparam int TIMEOUT_CYCLES = 3000;  // far above the test length

	logic        clk;
	logic        rst_n;
	disp_req_t   disp_req;
	cdb_t        cdb;
	complete_t   complete;
	rename_rsp_t rename_rsp;
	retire_t     retire;
	logic        stall;
	int          cycles = 0;

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	preg_idx_t m_map  [ARCH_REG_NUM];
	logic      m_rdy  [PREG_NUM];
	preg_idx_t m_free_q [$];
	logic      m_done [ROB_DEPTH];  // slot in rob and completed
	areg_idx_t m_areg [ROB_DEPTH];
	preg_idx_t m_new  [ROB_DEPTH];
	preg_idx_t m_old  [ROB_DEPTH];
	int        m_head;
	int        m_tail;
	int        m_count;
	int        pop_count;           // tags taken from the free list so far
	preg_idx_t retired_old_q [$];   // every Told in retirement order
	retire_t   retired_q [$];       // retire_o as seen, in order

	tb_clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

	rename_core #(.ROB_DEPTH(ROB_DEPTH)) dut_i (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.disp_req_i   (disp_req),
		.cdb_i        (cdb),
		.complete_i   (complete),
		.rename_rsp_o (rename_rsp),
		.retire_o     (retire),
		.stall_o      (stall)
	);

	//----------------------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------------------
	task automatic preg_eq(input string name, input preg_idx_t got, input preg_idx_t exp);
		if (got !== exp) begin
			$display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic rob_idx_eq(input string name, input rob_idx_t got, input rob_idx_t exp);
		if (got !== exp) begin
			$display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic bit_eq(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// payload only matters when a retirement is expected
	task automatic retire_eq(input retire_t got, input retire_t exp);
		if ((got.valid !== exp.valid) || (exp.valid && (got !== exp))) begin
			$display("** Error retire_o: got 0x%h, expected 0x%h", got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic void model_reset();
		for (int i = 0; i < ARCH_REG_NUM; i++) m_map[i] = preg_idx_t'(i);  // identity
		for (int i = 0; i < PREG_NUM; i++) m_rdy[i] = 1'b1;
		for (int i = 0; i < ROB_DEPTH; i++) m_done[i] = 1'b0;
		m_free_q = {};
		for (int i = 0; i < ROB_DEPTH_MAX; i++) begin
			m_free_q.push_back(preg_idx_t'(ARCH_REG_NUM + i));
		end
		m_head    = 0;
		m_tail    = 0;
		m_count   = 0;
		pop_count = 0;
	endfunction

	//----------------------------------------------------------------------
	// per cycle check and model step
	//----------------------------------------------------------------------
	task automatic check_outputs();
		logic      exp_stall;
		logic      fire;
		preg_idx_t pa;
		preg_idx_t pb;
		preg_idx_t tnew;
		retire_t   exp_ret;
		exp_stall = (m_count == ROB_DEPTH);
		fire      = disp_req.valid && !exp_stall;
		exp_ret   = '0;
		if (m_count > 0 && m_done[m_head])
			exp_ret = '{valid: 1'b1, areg: m_areg[m_head], new_preg: m_new[m_head],
			            old_preg: m_old[m_head]};
		bit_eq("stall_o", stall, exp_stall);
		bit_eq("rename_rsp_o.valid", rename_rsp.valid, fire);
		retire_eq(retire, exp_ret);
		pa = m_map[disp_req.opa_areg];
		pb = m_map[disp_req.opb_areg];
		if (fire) begin
			preg_eq("rename_rsp_o.dest_preg", rename_rsp.dest_preg, m_free_q[0]);
			preg_eq("rename_rsp_o.old_preg", rename_rsp.old_preg, m_map[disp_req.dest_areg]);
			preg_eq("rename_rsp_o.opa_preg", rename_rsp.opa_preg, pa);
			preg_eq("rename_rsp_o.opb_preg", rename_rsp.opb_preg, pb);
			bit_eq("rename_rsp_o.opa_rdy", rename_rsp.opa_rdy,
			       m_rdy[pa] | (cdb.valid && cdb.preg == pa));
			bit_eq("rename_rsp_o.opb_rdy", rename_rsp.opb_rdy,
			       m_rdy[pb] | (cdb.valid && cdb.preg == pb));
			rob_idx_eq("rename_rsp_o.rob_idx", rename_rsp.rob_idx, rob_idx_t'(m_tail));
		end
		// everything below lands at the coming rising edge
		if (complete.valid) m_done[int'(complete.rob_idx) % ROB_DEPTH] = 1'b1;
		if (exp_ret.valid) begin
			m_done[m_head] = 1'b0;
			m_free_q.push_back(exp_ret.old_preg);
			retired_old_q.push_back(exp_ret.old_preg);
			retired_q.push_back(retire);
			m_head  = (m_head + 1) % ROB_DEPTH;
			m_count = m_count - 1;
		end
		if (cdb.valid) m_rdy[cdb.preg] = 1'b1;
		if (fire) begin  // after the wakeup, so the clear wins
			tnew                     = m_free_q.pop_front();
			m_old[m_tail]            = m_map[disp_req.dest_areg];
			m_map[disp_req.dest_areg] = tnew;
			m_rdy[tnew]              = 1'b0;
			m_areg[m_tail]           = disp_req.dest_areg;
			m_new[m_tail]            = tnew;
			m_tail                   = (m_tail + 1) % ROB_DEPTH;
			m_count                  = m_count + 1;
			pop_count                = pop_count + 1;
		end
	endtask

	task automatic run_cycle(input disp_req_t r, input cdb_t c, input complete_t m);
		@(posedge clk);
		disp_req <= r;
		cdb      <= c;
		complete <= m;
		@(negedge clk);
		check_outputs();
	endtask

	// hold the request until it is accepted
	task automatic dispatch(input areg_idx_t d, input areg_idx_t a, input areg_idx_t b,
	                        input cdb_t c, output rename_rsp_t rsp);
		disp_req_t r;
		r = '{valid: 1'b1, dest_areg: d, opa_areg: a, opb_areg: b};
		do begin
			run_cycle(r, c, '0);
		end while (!rename_rsp.valid);
		rsp = rename_rsp;
	endtask

	task automatic complete_slot(input int idx);
		run_cycle('0, '0, '{valid: 1'b1, rob_idx: rob_idx_t'(idx)});
	endtask

	// complete every busy slot oldest first, then wait for an empty rob
	task automatic drain();
		int n;
		int h;
		n = m_count;
		h = m_head;
		for (int i = 0; i < n; i++) begin
			if (!m_done[(h + i) % ROB_DEPTH]) complete_slot((h + i) % ROB_DEPTH);
		end
		while (m_count != 0) run_cycle('0, '0, '0);
	endtask

	function automatic areg_idx_t rand_areg(input int lo, input int hi);
		return areg_idx_t'($urandom_range(hi, lo));
	endfunction

	//----------------------------------------------------------------------
	// tests
	//----------------------------------------------------------------------
	task automatic reset_rename_test();
		rename_rsp_t rsp;
		areg_idx_t   d;
		areg_idx_t   a;
		run_cycle('0, '0, '0);  // quiet outputs right after reset
		for (int i = 0; i < 4; i++) begin
			d = areg_idx_t'(4 * i + $urandom_range(3, 1));  // distinct dests 1..15
			a = rand_areg(16, 31);
			dispatch(d, a, rand_areg(16, 31), '0, rsp);
			preg_eq("rename_rsp_o.dest_preg", rsp.dest_preg, preg_idx_t'(ARCH_REG_NUM + i));
			preg_eq("rename_rsp_o.old_preg", rsp.old_preg, preg_idx_t'(d));
			preg_eq("rename_rsp_o.opa_preg", rsp.opa_preg, preg_idx_t'(a));
			bit_eq("rename_rsp_o.opa_rdy", rsp.opa_rdy, 1'b1);
		end
		drain();
	endtask

	task automatic wakeup_test();
		rename_rsp_t rsp;
		preg_idx_t   p1;
		dispatch(5'd7, rand_areg(16, 31), rand_areg(16, 31), '0, rsp);
		p1 = rsp.dest_preg;
		dispatch(5'd9, 5'd7, 5'd9, '0, rsp);  // opb reads its own old mapping
		preg_eq("rename_rsp_o.opa_preg", rsp.opa_preg, p1);
		bit_eq("rename_rsp_o.opa_rdy", rsp.opa_rdy, 1'b0);
		dispatch(5'd10, 5'd7, rand_areg(16, 31), '{valid: 1'b1, preg: p1}, rsp);
		bit_eq("rename_rsp_o.opa_rdy", rsp.opa_rdy, 1'b1);  // cdb bypass
		dispatch(5'd11, rand_areg(16, 31), 5'd7, '0, rsp);
		preg_eq("rename_rsp_o.opb_preg", rsp.opb_preg, p1);
		bit_eq("rename_rsp_o.opb_rdy", rsp.opb_rdy, 1'b1);  // stored bit
		drain();
	endtask

	task automatic inorder_retire_test();
		rename_rsp_t rsp;
		int          slot [6];
		preg_idx_t   order_q [$];
		int          base;
		int          j;
		int          t;
		base = retired_q.size();
		for (int i = 0; i < 6; i++) begin
			slot[i] = m_tail;  // model slot of this dispatch
			dispatch(rand_areg(1, 31), rand_areg(0, 31), rand_areg(0, 31), '0, rsp);
			order_q.push_back(m_new[slot[i]]);
		end
		for (int i = 5; i > 0; i--) begin  // shuffle the completion order
			j       = $urandom_range(i, 0);
			t       = slot[i];
			slot[i] = slot[j];
			slot[j] = t;
		end
		for (int i = 0; i < 6; i++) complete_slot(slot[i]);
		while (m_count != 0) run_cycle('0, '0, '0);
		for (int i = 0; i < 6; i++)
			preg_eq("retire_o.new_preg", retired_q[base + i].new_preg, order_q[i]);
	endtask

	task automatic rob_full_test();
		rename_rsp_t rsp;
		disp_req_t   held;
		rob_idx_t    exp_idx;
		for (int i = 0; i < ROB_DEPTH; i++)
			dispatch(rand_areg(1, 31), rand_areg(0, 31), rand_areg(0, 31), '0, rsp);
		held    = '{valid: 1'b1, dest_areg: rand_areg(1, 31), opa_areg: rand_areg(0, 31),
		            opb_areg: rand_areg(0, 31)};
		exp_idx = rob_idx_t'(m_tail);
		repeat (3) begin
			run_cycle(held, '0, '0);
			bit_eq("stall_o", stall, 1'b1);
			bit_eq("rename_rsp_o.valid", rename_rsp.valid, 1'b0);
		end
		run_cycle(held, '0, '{valid: 1'b1, rob_idx: rob_idx_t'(m_head)});
		dispatch(held.dest_areg, held.opa_areg, held.opb_areg, '0, rsp);
		rob_idx_eq("rename_rsp_o.rob_idx", rsp.rob_idx, exp_idx);
		drain();
	endtask

	// past the first ROB_DEPTH_MAX pops every tag is a recycled Told
	task automatic tag_recycle_test();
		rename_rsp_t rsp;
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < 4; i++) begin
				dispatch(rand_areg(1, 31), rand_areg(0, 31), rand_areg(0, 31), '0, rsp);
				if (pop_count > ROB_DEPTH_MAX)
					preg_eq("rename_rsp_o.dest_preg", rsp.dest_preg,
					        retired_old_q[pop_count - 1 - ROB_DEPTH_MAX]);
			end
			drain();
		end
	endtask

	//----------------------------------------------------------------------
	// run control
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, tests still running after %0d cycles", cycles);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int seed_ret;
		disp_req = '0;
		cdb      = '0;
		complete = '0;
		seed_ret = $urandom(32'he717);
		model_reset();
		wait (rst_n === 1'b1);
		reset_rename_test();
		wakeup_test();
		inorder_retire_test();
		rob_full_test();
		tag_recycle_test();
		if (pop_count <= ROB_DEPTH_MAX) begin
			$display("tag recycling never reached, only %0d tags were used", pop_count);
			$display("Result: FAILED");
			$fatal(1, "coverage gap");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule : rename_core_tb

/* rename_core.f */
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/rob.sv
src/rename_core.sv
verif/tb_clk_gen.sv
verif/rename_core_chk.sv
verif/rename_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rename core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module rename_core_tb -f rename_core.f \
	-Mdir obj_dir -o rename_core_sim

# the log decides pass or fail, a nonzero exit alone does not stop the script here
./obj_dir/rename_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
grep -q "Result: PASSED" sim.log
